//--- common/dmem_settings.svh
`ifndef DMEM_SETTINGS_SVH
`define DMEM_SETTINGS_SVH

// data path width
`define XLEN        64

// register file and CSR addressing
`define REG_ADDR_W  5
`define CSR_ADDR_W  12

`define INST_LEN    32

// trap bus, bit 0 is the misaligned access flag
`define TRAP_W      8

// data RAM geometry in 64-bit words
`define DMEM_WORDS  256
`define DMEM_IDX_W  8

`endif

//--- common/memop_pkg.sv
`default_nettype none

package memop_pkg;

  // memory operation as decoded in the execute stage
  typedef enum logic [3:0] {
    NONE = 4'd0,
    LB   = 4'd1,
    LBU  = 4'd2,
    LH   = 4'd3,
    LHU  = 4'd4,
    LW   = 4'd5,
    LWU  = 4'd6,
    LD   = 4'd7,
    SB   = 4'd8,
    SH   = 4'd9,
    SW   = 4'd10,
    SD   = 4'd11
  } mem_op_e;

  // access size, log2 of the byte count
  typedef enum logic [1:0] {
    B = 2'd0,
    H = 2'd1,
    W = 2'd2,
    D = 2'd3
  } acc_size_e;

  // what the extend stage needs to know about the access in flight
  typedef struct packed {
    logic      is_load;
    logic      is_signed;
    acc_size_e size;
    logic [2:0] offset;
    logic      misaligned;
  } lane_cmd_t;

endpackage

`default_nettype wire

//--- common/pipe_pkg.sv
`default_nettype none

`include "dmem_settings.svh"

package pipe_pkg;

  // execute to memory pipeline record
  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`INST_LEN-1:0]   inst;
    logic [`REG_ADDR_W-1:0] rd_idx;
    logic [`XLEN-1:0]       rs2_data;
    memop_pkg::mem_op_e     mem_op;
    logic [`XLEN-1:0]       alu_data;    // also the access address
    logic [`CSR_ADDR_W-1:0] csr_addr;
    logic [`XLEN-1:0]       csr_data;
    logic                   csr_valid;
    logic [`TRAP_W-1:0]     trap;
  } ex_mem_t;

  // memory to writeback pipeline record
  typedef struct packed {
    logic [`XLEN-1:0]       pc;
    logic [`INST_LEN-1:0]   inst;
    logic [`REG_ADDR_W-1:0] rd_idx;
    logic [`XLEN-1:0]       wb_data;
    logic [`CSR_ADDR_W-1:0] csr_addr;
    logic [`XLEN-1:0]       csr_data;
    logic                   csr_valid;
    logic [`TRAP_W-1:0]     trap;
  } mem_wb_t;

endpackage

`default_nettype wire

//--- hdl/dmem_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module dmem_stage_top (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              valid_i,
  input  pipe_pkg::ex_mem_t ex_i,
  output logic              valid_o,
  output pipe_pkg::mem_wb_t wb_o
);
  import memop_pkg::*;

  logic [`DMEM_IDX_W-1:0] word_idx;
  logic [7:0]             lane_we;
  logic [7:0][7:0]        lane_wdata;
  logic [7:0][7:0]        rd_bytes;
  lane_cmd_t              cmd;

  store_steer u_steer (
    .valid_i      (valid_i),
    .ex_i         (ex_i),
    .word_idx_o   (word_idx),
    .lane_we_o    (lane_we),
    .lane_wdata_o (lane_wdata),
    .cmd_o        (cmd)
  );

  // one bank per byte lane, all sharing the word index
  for (genvar k = 0; k < 8; k++) begin : g_lane
    byte_lane_ram u_bank (
      .clk     (clk),
      .we_i    (lane_we[k]),
      .idx_i   (word_idx),
      .wdata_i (lane_wdata[k]),
      .rdata_o (rd_bytes[k])
    );
  end

  load_extend u_extend (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_i),
    .cmd_i      (cmd),
    .ex_i       (ex_i),
    .rd_bytes_i (rd_bytes),
    .valid_o    (valid_o),
    .wb_o       (wb_o)
  );

endmodule

`default_nettype wire

//--- mem_stage/byte_lane_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module byte_lane_ram (
  input  logic                   clk,
  input  logic                   we_i,
  input  logic [`DMEM_IDX_W-1:0] idx_i,
  input  logic [7:0]             wdata_i,
  output logic [7:0]             rdata_o
);

  // one byte of every data word
  logic [7:0] mem [`DMEM_WORDS];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[idx_i] <= wdata_i;
    end
  end

  // read every cycle, old data on a same-index write
  always_ff @(posedge clk) begin
    rdata_o <= mem[idx_i];
  end

endmodule

`default_nettype wire

//--- mem_stage/load_extend.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module load_extend (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 valid_i,
  input  memop_pkg::lane_cmd_t cmd_i,
  input  pipe_pkg::ex_mem_t    ex_i,
  input  logic [7:0][7:0]      rd_bytes_i,
  output logic                 valid_o,
  output pipe_pkg::mem_wb_t    wb_o
);
  import memop_pkg::*;
  import pipe_pkg::*;

  logic             valid_q;
  lane_cmd_t        cmd_q;
  ex_mem_t          ex_q;
  logic [`XLEN-1:0] shifted;
  logic [`XLEN-1:0] load_val;

  // captured on the same edge as the bank read
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      cmd_q   <= '0;
      ex_q    <= '0;
    end else begin
      valid_q <= valid_i;
      cmd_q   <= cmd_i;
      ex_q    <= ex_i;
    end
  end

  // bring the addressed bytes down to bit 0
  assign shifted = rd_bytes_i >> {cmd_q.offset, 3'b000};

  always_comb begin
    case (cmd_q.size)
      B: load_val = {{(`XLEN-8){cmd_q.is_signed & shifted[7]}}, shifted[7:0]};
      H: load_val = {{(`XLEN-16){cmd_q.is_signed & shifted[15]}}, shifted[15:0]};
      W: load_val = {{(`XLEN-32){cmd_q.is_signed & shifted[31]}}, shifted[31:0]};
      default: load_val = shifted;
    endcase
    // misaligned loads return no memory data
    if (cmd_q.misaligned) begin
      load_val = '0;
    end
  end

  assign valid_o = valid_q;

  // wb_data doubles as the bypass value for the decode stage
  always_comb begin
    wb_o.pc        = ex_q.pc;
    wb_o.inst      = ex_q.inst;
    wb_o.rd_idx    = ex_q.rd_idx;
    wb_o.wb_data   = cmd_q.is_load ? load_val : ex_q.alu_data;
    wb_o.csr_addr  = ex_q.csr_addr;
    wb_o.csr_data  = ex_q.csr_data;
    wb_o.csr_valid = ex_q.csr_valid;
    wb_o.trap      = {ex_q.trap[`TRAP_W-1:1], ex_q.trap[0] | cmd_q.misaligned};
  end

endmodule

`default_nettype wire

//--- mem_stage/store_steer.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module store_steer (
  input  logic                   valid_i,
  input  pipe_pkg::ex_mem_t      ex_i,
  output logic [`DMEM_IDX_W-1:0] word_idx_o,
  output logic [7:0]             lane_we_o,
  output logic [7:0][7:0]        lane_wdata_o,
  output memop_pkg::lane_cmd_t   cmd_o
);
  import memop_pkg::*;

  logic      is_load;
  logic      is_store;
  logic      is_signed;
  acc_size_e size;
  logic [7:0] size_mask;
  logic [2:0] align_mask;
  logic [2:0] offset;
  logic      misaligned;

  assign is_load   = ex_i.mem_op inside {LB, LBU, LH, LHU, LW, LWU, LD};
  assign is_store  = ex_i.mem_op inside {SB, SH, SW, SD};
  assign is_signed = ex_i.mem_op inside {LB, LH, LW, LD};

  // decode size, lane footprint at offset 0 and alignment mask
  always_comb begin
    case (ex_i.mem_op)
      LB, LBU, SB: size = B;
      LH, LHU, SH: size = H;
      LW, LWU, SW: size = W;
      default:     size = D;
    endcase
    case (size)
      B: begin
        size_mask  = 8'h01;
        align_mask = 3'b000;
      end
      H: begin
        size_mask  = 8'h03;
        align_mask = 3'b001;
      end
      W: begin
        size_mask  = 8'h0f;
        align_mask = 3'b011;
      end
      default: begin
        size_mask  = 8'hff;
        align_mask = 3'b111;
      end
    endcase
  end

  assign offset     = ex_i.alu_data[2:0];
  assign misaligned = (is_load || is_store) && |(offset & align_mask);

  // upper address bits are dropped so accesses wrap
  assign word_idx_o = ex_i.alu_data[3 +: `DMEM_IDX_W];

  // misaligned stores are suppressed entirely
  assign lane_we_o = (valid_i && is_store && !misaligned) ? (size_mask << offset) : 8'h00;

  // byte j of rs2 lands on lane offset+j
  assign lane_wdata_o = ex_i.rs2_data << {offset, 3'b000};

  assign cmd_o = '{
    is_load:    is_load,
    is_signed:  is_signed,
    size:       size,
    offset:     offset,
    misaligned: misaligned
  };

endmodule

`default_nettype wire

//--- project.f
+incdir+common
common/memop_pkg.sv
common/pipe_pkg.sv
mem_stage/store_steer.sv
mem_stage/byte_lane_ram.sv
mem_stage/load_extend.sv
hdl/dmem_stage_top.sv
tb/dmem_checker.sv
tb/tb_dmem_stage.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_dmem_stage -f project.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "run failed, see sim.log"
  exit 1
fi

if ! grep -q "SIMULATION PASSED" sim.log; then
  echo "run ended without a result, see sim.log"
  exit 1
fi

echo "run passed"

//--- tb/dmem_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "dmem_settings.svh"

module dmem_checker (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              valid_i,
  input  pipe_pkg::ex_mem_t ex_i,
  input  logic              dut_valid_i,
  input  pipe_pkg::mem_wb_t dut_wb_i,
  output int                mismatch_cnt_o,
  output int                other_err_cnt_o,
  output int                resolved_cnt_o
);
  import memop_pkg::*;
  import pipe_pkg::*;

  // byte image of the RAM, indexed by the low address bits
  logic [7:0] shadow [`DMEM_WORDS*8];
  mem_wb_t    exp_q [$];
  mem_wb_t    head;
  logic       expect_out = 1'b0;
  int         mismatches = 0;
  int         other_errs = 0;
  int         resolved = 0;

  assign mismatch_cnt_o  = mismatches;
  assign other_err_cnt_o = other_errs;
  assign resolved_cnt_o  = resolved;

  function automatic int access_bytes(input mem_op_e op);
    case (op)
      LB, LBU, SB: return 1;
      LH, LHU, SH: return 2;
      LW, LWU, SW: return 4;
      LD, SD:      return 8;
      default:     return 0;
    endcase
  endfunction

  function automatic logic is_misaligned(input ex_mem_t ex);
    int n;
    n = access_bytes(ex.mem_op);
    if (n == 0) begin
      return 1'b0;
    end
    return (ex.alu_data[2:0] & 3'(n - 1)) != 3'd0;
  endfunction

  // expected writeback record, built from the shadow before this access
  function automatic mem_wb_t expected_result(input ex_mem_t ex);
    mem_wb_t                r;
    int                     n;
    int                     j;
    logic                   misal;
    logic                   is_load;
    logic [63:0]            val;
    logic [`DMEM_IDX_W+2:0] idx;
    n       = access_bytes(ex.mem_op);
    misal   = is_misaligned(ex);
    is_load = ex.mem_op inside {LB, LBU, LH, LHU, LW, LWU, LD};
    val     = '0;
    if (is_load && !misal) begin
      for (j = 0; j < n; j++) begin
        idx = ex.alu_data[`DMEM_IDX_W+2:0] + (`DMEM_IDX_W+3)'(j);
        val[8*j +: 8] = shadow[idx];
      end
      if (ex.mem_op inside {LB, LH, LW} && |(val & (64'h1 << (8*n - 1)))) begin
        val = val | (~64'h0 << (8*n));
      end
    end
    r.pc        = ex.pc;
    r.inst      = ex.inst;
    r.rd_idx    = ex.rd_idx;
    r.wb_data   = is_load ? val : ex.alu_data;
    r.csr_addr  = ex.csr_addr;
    r.csr_data  = ex.csr_data;
    r.csr_valid = ex.csr_valid;
    r.trap      = ex.trap;
    r.trap[0]   = ex.trap[0] | misal;
    return r;
  endfunction

  task automatic apply_store(input ex_mem_t ex);
    int                     j;
    logic [`DMEM_IDX_W+2:0] idx;
    if (ex.mem_op inside {SB, SH, SW, SD} && !is_misaligned(ex)) begin
      for (j = 0; j < access_bytes(ex.mem_op); j++) begin
        idx = ex.alu_data[`DMEM_IDX_W+2:0] + (`DMEM_IDX_W+3)'(j);
        shadow[idx] = ex.rs2_data[8*j +: 8];
      end
    end
  endtask

  task automatic check_field(input string name, input logic [63:0] exp_v,
                             input logic [63:0] act_v);
    if (act_v !== exp_v) begin
      $display("Mismatch at time %0t: %s expected %h actual %h", $time, name, exp_v, act_v);
      mismatches++;
    end
  endtask

  task automatic compare_outputs(input mem_wb_t e);
    check_field("wb_o.pc", e.pc, dut_wb_i.pc);
    check_field("wb_o.inst", 64'(e.inst), 64'(dut_wb_i.inst));
    check_field("wb_o.rd_idx", 64'(e.rd_idx), 64'(dut_wb_i.rd_idx));
    check_field("wb_o.wb_data", e.wb_data, dut_wb_i.wb_data);
    check_field("wb_o.csr_addr", 64'(e.csr_addr), 64'(dut_wb_i.csr_addr));
    check_field("wb_o.csr_data", e.csr_data, dut_wb_i.csr_data);
    check_field("wb_o.csr_valid", 64'(e.csr_valid), 64'(dut_wb_i.csr_valid));
    check_field("wb_o.trap", 64'(e.trap), 64'(dut_wb_i.trap));
  endtask

  // outputs seen here belong to the instruction sampled one edge earlier
  always @(posedge clk) begin
    if (expect_out) begin
      head = exp_q.pop_front();
      if (dut_valid_i !== 1'b1) begin
        $display("valid_o missing at time %0t one cycle after an accepted instruction",
                 $time);
        other_errs++;
      end else begin
        compare_outputs(head);
      end
      resolved++;
    end else if (dut_valid_i !== 1'b0) begin
      $display("valid_o high at time %0t without an instruction one cycle earlier", $time);
      other_errs++;
    end
    expect_out = rst_n_i && valid_i;
    if (expect_out) begin
      exp_q.push_back(expected_result(ex_i));
      apply_store(ex_i);
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_dmem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dmem_stage;
  import memop_pkg::*;
  import pipe_pkg::*;

  localparam int NUM_RANDOM    = 600;
  localparam int DRAIN_TIMEOUT = 16;

  logic        clk;
  logic        rst_n;
  logic        valid_in;
  ex_mem_t     ex_in;
  logic        valid_out;
  mem_wb_t     wb_out;
  logic [63:0] rng;
  int          n_issued;
  int          mismatches;
  int          other_errs;
  int          resolved;

  dmem_stage_top dut0 (
    .clk     (clk),
    .rst_n_i (rst_n),
    .valid_i (valid_in),
    .ex_i    (ex_in),
    .valid_o (valid_out),
    .wb_o    (wb_out)
  );

  dmem_checker u_checker (
    .clk             (clk),
    .rst_n_i         (rst_n),
    .valid_i         (valid_in),
    .ex_i            (ex_in),
    .dut_valid_i     (valid_out),
    .dut_wb_i        (wb_out),
    .mismatch_cnt_o  (mismatches),
    .other_err_cnt_o (other_errs),
    .resolved_cnt_o  (resolved)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [63:0] xorshift64(input logic [63:0] s);
    logic [63:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  // random sideband and random address bits above the RAM index to exercise wrap
  task automatic issue_instr(input mem_op_e op, input logic [5:0] win_off,
                             input logic [63:0] data);
    ex_mem_t ex;
    rng = xorshift64(rng);
    ex.pc = rng;
    rng = xorshift64(rng);
    ex.inst      = rng[31:0];
    ex.rd_idx    = rng[36:32];
    ex.csr_addr  = rng[48:37];
    ex.csr_valid = rng[49];
    ex.trap      = rng[57:50];
    rng = xorshift64(rng);
    ex.csr_data = rng;
    rng = xorshift64(rng);
    ex.alu_data = {rng[63:11], 5'b00000, win_off};
    ex.rs2_data = data;
    ex.mem_op   = op;
    @(posedge clk);
    valid_in <= 1'b1;
    ex_in    <= ex;
    n_issued++;
  endtask

  // bubble carrying a store that must not reach the RAM
  task automatic idle_cycle();
    ex_mem_t ex;
    rng = xorshift64(rng);
    ex = '0;
    ex.mem_op   = SD;
    ex.alu_data = {58'd0, rng[5:3], 3'b000};
    ex.rs2_data = rng;
    @(posedge clk);
    valid_in <= 1'b0;
    ex_in    <= ex;
  endtask

  initial begin
    int          i;
    int          op_idx;
    int          wait_cycles;
    mem_op_e     op;
    logic [2:0]  word;
    logic [2:0]  off;
    logic [63:0] data;
    rng      = 64'd49131;
    n_issued = 0;
    rst_n    = 1'b0;
    valid_in = 1'b0;
    ex_in    = '0;
    word     = 3'd0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    // fill the window so every later load sees known bytes
    for (i = 0; i < 8; i++) begin
      rng = xorshift64(rng);
      issue_instr(SD, {i[2:0], 3'b000}, rng);
    end
    // store then narrower loads back to back
    issue_instr(SD, 6'h08, 64'hf1e2_d3c4_b5a6_9788);
    issue_instr(LB, 6'h0f, 64'd0);
    issue_instr(LHU, 6'h0c, 64'd0);
    issue_instr(LW, 6'h08, 64'd0);
    issue_instr(LWU, 6'h0c, 64'd0);
    issue_instr(LD, 6'h08, 64'd0);
    issue_instr(SB, 6'h13, 64'h80);
    issue_instr(LH, 6'h12, 64'd0);
    issue_instr(LD, 6'h10, 64'd0);
    // misaligned accesses followed by aligned loads of the same word
    issue_instr(SW, 6'h1a, 64'hdead_beef_dead_beef);
    issue_instr(LW, 6'h19, 64'd0);
    issue_instr(LD, 6'h18, 64'd0);
    issue_instr(SH, 6'h21, 64'h1234);
    issue_instr(LD, 6'h20, 64'd0);
    issue_instr(NONE, 6'h05, 64'd0);
    idle_cycle();
    for (i = 0; i < NUM_RANDOM; i++) begin
      rng = xorshift64(rng);
      if (rng[2:0] == 3'd0) begin
        idle_cycle();
      end else begin
        op_idx = rng[63:32] % 12;
        op = mem_op_e'(op_idx[3:0]);
        // stay on the last word half the time
        if (rng[3]) begin
          word = rng[10:8];
        end
        off = rng[13:11];
        if (rng[15:14] != 2'b00) begin
          case (op)
            LH, LHU, SH: off[0] = 1'b0;
            LW, LWU, SW: off[1:0] = 2'b00;
            LD, SD:      off = 3'b000;
            default:     off = off;
          endcase
        end
        rng = xorshift64(rng);
        data = rng;
        issue_instr(op, {word, off}, data);
      end
    end
    idle_cycle();
    wait_cycles = 0;
    while (resolved < n_issued && wait_cycles < DRAIN_TIMEOUT) begin
      @(negedge clk);
      wait_cycles++;
    end
    $display("instructions %0d, outputs checked %0d, mismatches %0d, other errors %0d",
             n_issued, resolved, mismatches, other_errs);
    if (resolved < n_issued) begin
      $display("timed out waiting for the last output of the stage");
      $display("SIMULATION FAILED");
    end else if (mismatches == 0 && other_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
